// File: verilog/ofdmTxPkg.sv
`default_nettype none

package ofdmTxPkg;

        typedef enum logic [1:0] {
                MOD_BPSK  = 2'd0,
                MOD_QPSK  = 2'd1,
                MOD_QAM16 = 2'd2,
                MOD_QAM64 = 2'd3
        } modType;

        // First stream bit sits in bit 0 and unused upper bits stay zero
        typedef logic [5:0] bitGroup;

        // Q2.14 fixed point where 16'h4000 is +1.0
        typedef logic signed [15:0] sample;

        typedef logic [31:0] iqPair;            // I in the upper half, Q in the lower

        typedef logic [3:0]  axiAddr;
        typedef logic [31:0] axiData;

        ////////////////////////////////////////////////////////////////////////////
        // Register map

        localparam axiAddr REG_CTRL   = 4'h0;   // Mode in 1:0, enable in 2
        localparam axiAddr REG_STATUS = 4'h4;   // Busy in 0
        localparam axiAddr REG_COUNT  = 4'h8;   // Emitted IQ pairs

endpackage

`default_nettype wire

// File: verilog/bitGroupIf.sv
`default_nettype none

interface bitGroupIf;

        logic               valid;
        logic               ready;
        ofdmTxPkg::bitGroup bits;
        ofdmTxPkg::modType  mode;               // Mode in force when the group was cut

        modport source (
                output valid,
                output bits,
                output mode,
                input  ready
        );

        modport sink (
                input  valid,
                input  bits,
                input  mode,
                output ready
        );

endinterface

`default_nettype wire

// File: verilog/txMapConfig.sv
`default_nettype none

module txMapConfig #(
        parameter int COUNT_WIDTH = 16
) (
        input  logic              clk,
        input  logic              reset,
        input  ofdmTxPkg::axiAddr awaddr,
        input  logic              awvalid,
        output logic              awready,
        input  ofdmTxPkg::axiData wdata,
        input  logic [3:0]        wstrb,
        input  logic              wvalid,
        output logic              wready,
        output logic [1:0]        bresp,
        output logic              bvalid,
        input  logic              bready,
        input  ofdmTxPkg::axiAddr araddr,
        input  logic              arvalid,
        output logic              arready,
        output ofdmTxPkg::axiData rdata,
        output logic [1:0]        rresp,
        output logic              rvalid,
        input  logic              rready,
        output ofdmTxPkg::modType mode,
        output logic              enable,
        input  logic              busy,
        input  logic              sampleStrobe
);

        ofdmTxPkg::axiAddr      awAddrHeld;
        ofdmTxPkg::axiData      wDataHeld;
        logic [3:0]             wStrbHeld;
        logic                   awFull;
        logic                   wFull;
        logic                   doWrite;
        logic                   ctrlWrite;
        logic                   countWrite;
        logic [COUNT_WIDTH-1:0] sampleCount;
        ofdmTxPkg::axiData      readValue;

        ////////////////////////////////////////////////////////////////////////////
        // Write channel

        assign awready    = !bvalid && !awFull;
        assign wready     = !bvalid && !wFull;
        assign bresp      = 2'b00;
        assign doWrite    = awFull && wFull;    // Both phases in, commit on this edge
        assign ctrlWrite  = doWrite && (awAddrHeld == ofdmTxPkg::REG_CTRL) && wStrbHeld[0];
        assign countWrite = doWrite && (awAddrHeld == ofdmTxPkg::REG_COUNT);

        always_ff @(posedge clk) begin
                if (awvalid && awready) begin
                        awAddrHeld <= awaddr;
                end
                if (wvalid && wready) begin
                        wDataHeld <= wdata;
                        wStrbHeld <= wstrb;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        awFull <= 1'b0;
                        wFull  <= 1'b0;
                        bvalid <= 1'b0;
                end else if (doWrite) begin
                        awFull <= 1'b0;
                        wFull  <= 1'b0;
                        bvalid <= 1'b1;
                end else begin
                        if (awvalid && awready) begin
                                awFull <= 1'b1;
                        end
                        if (wvalid && wready) begin
                                wFull <= 1'b1;
                        end
                        if (bready) begin
                                bvalid <= 1'b0;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        mode        <= ofdmTxPkg::MOD_BPSK;
                        enable      <= 1'b0;
                        sampleCount <= '0;
                end else begin
                        if (ctrlWrite) begin
                                mode   <= ofdmTxPkg::modType'(wDataHeld[1:0]);
                                enable <= wDataHeld[2];
                        end
                        if (countWrite) begin
                                sampleCount <= '0;              // Clear wins over a strobe
                        end else if (sampleStrobe) begin
                                sampleCount <= sampleCount + 1'b1;
                        end
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Read channel

        assign arready = !rvalid;
        assign rresp   = 2'b00;

        always_comb begin
                case (araddr)
                        ofdmTxPkg::REG_CTRL:   readValue = {29'd0, enable, mode};
                        ofdmTxPkg::REG_STATUS: readValue = {31'd0, busy};
                        ofdmTxPkg::REG_COUNT:  readValue = ofdmTxPkg::axiData'(sampleCount);
                        default:               readValue = '0;
                endcase
        end

        always_ff @(posedge clk) begin
                if (arvalid && arready) begin
                        rdata <= readValue;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        rvalid <= 1'b0;
                end else if (arvalid && arready) begin
                        rvalid <= 1'b1;
                end else if (rready) begin
                        rvalid <= 1'b0;
                end
        end

        // A write response stays up until the master takes it
        bvalidHeld: assert property (@(posedge clk) disable iff (reset)
                bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

// File: verilog/bitGrouper.sv
`default_nettype none

module bitGrouper (
        input  logic              clk,
        input  logic              reset,
        input  ofdmTxPkg::modType mode,
        input  logic              enable,
        input  logic [7:0]        byteData,
        input  logic              byteValid,
        output logic              byteReady,
        bitGroupIf.source         grp,
        input  logic              mapperFull,
        output logic              busy
);

        localparam int STORE_BITS = 13;

        ofdmTxPkg::modType     curMode;
        logic [3:0]            nBpsc;
        ofdmTxPkg::bitGroup    groupMask;
        logic [STORE_BITS-1:0] store;
        logic [STORE_BITS-1:0] shifted;
        logic [3:0]            fill;
        logic [3:0]            remain;
        logic                  take;
        logic                  accept;

        always_comb begin
                case (curMode)
                        ofdmTxPkg::MOD_BPSK:  nBpsc = 4'd1;
                        ofdmTxPkg::MOD_QPSK:  nBpsc = 4'd2;
                        ofdmTxPkg::MOD_QAM16: nBpsc = 4'd4;
                        default:              nBpsc = 4'd6;
                endcase
        end

        assign groupMask = ~(6'h3F << nBpsc);

        // A byte is taken only if it fits whole, which always holds below one group
        assign byteReady = enable && (fill <= 4'(STORE_BITS - 8));
        assign accept    = byteValid && byteReady;

        assign grp.valid = (fill >= nBpsc);
        assign grp.bits  = store[5:0] & groupMask;
        assign grp.mode  = curMode;
        assign take      = grp.valid && grp.ready;

        assign busy = (fill != 4'd0) || mapperFull;

        ////////////////////////////////////////////////////////////////////////////
        // Shift store

        assign shifted = take ? (store >> nBpsc) : store;
        assign remain  = take ? (fill - nBpsc) : fill;

        always_ff @(posedge clk) begin
                if (reset) begin
                        store   <= '0;
                        fill    <= '0;
                        curMode <= ofdmTxPkg::MOD_BPSK;
                end else begin
                        if (accept) begin
                                // New byte lands just above the bits still held
                                store <= shifted | (STORE_BITS'(byteData) << remain);
                                fill  <= remain + 4'd8;
                        end else begin
                                store <= shifted;
                                fill  <= remain;
                        end
                        if (fill == 4'd0) begin
                                curMode <= mode;        // Mode only moves while empty
                        end
                end
        end

        fillBound: assert property (@(posedge clk) disable iff (reset)
                accept |=> fill <= 4'(STORE_BITS));

endmodule

`default_nettype wire

// File: verilog/modulation.sv
`default_nettype none

module modulation (
        input  logic             clk,
        input  logic             reset,
        bitGroupIf.sink          grp,
        output ofdmTxPkg::iqPair iqData,
        output logic             iqValid,
        input  logic             iqReady,
        output logic             full,
        output logic             sampleStrobe
);

        logic [2:0]       qBits;
        ofdmTxPkg::sample iLevel;
        ofdmTxPkg::sample qLevel;

        // Gray-coded level of one axis. Bit 0 picks the sign
        function automatic ofdmTxPkg::sample axisLevel(input ofdmTxPkg::modType m,
                                                       input logic [2:0] b);
                ofdmTxPkg::sample lvl;
                case (m)
                        ofdmTxPkg::MOD_BPSK:  lvl = b[0] ? 16'h4000 : 16'hC000;
                        ofdmTxPkg::MOD_QPSK:  lvl = b[0] ? 16'h2D41 : 16'hD2BF;
                        ofdmTxPkg::MOD_QAM16: begin
                                case (b[1:0])
                                        2'b00:   lvl = 16'hC349;
                                        2'b10:   lvl = 16'hEBC3;
                                        2'b11:   lvl = 16'h143D;
                                        default: lvl = 16'h3CB7;
                                endcase
                        end
                        default: begin
                                case (b)
                                        3'b000:  lvl = 16'hBAE0;
                                        3'b100:  lvl = 16'hCEA0;
                                        3'b110:  lvl = 16'hE260;
                                        3'b010:  lvl = 16'hF620;
                                        3'b011:  lvl = 16'h09E0;
                                        3'b111:  lvl = 16'h1DA0;
                                        3'b101:  lvl = 16'h3160;
                                        default: lvl = 16'h4520;
                                endcase
                        end
                endcase
                return lvl;
        endfunction

        ////////////////////////////////////////////////////////////////////////////
        // Mapping

        // I takes the low half of the group and Q the high half
        always_comb begin
                case (grp.mode)
                        ofdmTxPkg::MOD_QPSK:  qBits = {2'b00, grp.bits[1]};
                        ofdmTxPkg::MOD_QAM16: qBits = {1'b0, grp.bits[3:2]};
                        default:              qBits = grp.bits[5:3];
                endcase
        end

        assign iLevel = axisLevel(grp.mode, grp.bits[2:0]);
        assign qLevel = (grp.mode == ofdmTxPkg::MOD_BPSK) ? '0 : axisLevel(grp.mode, qBits);

        ////////////////////////////////////////////////////////////////////////////
        // Output register

        assign grp.ready    = !iqValid || iqReady;
        assign full         = iqValid;
        assign sampleStrobe = iqValid && iqReady;

        always_ff @(posedge clk) begin
                if (grp.valid && grp.ready) begin
                        iqData <= {iLevel, qLevel};
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        iqValid <= 1'b0;
                end else if (grp.valid && grp.ready) begin
                        iqValid <= 1'b1;
                end else if (iqReady) begin
                        iqValid <= 1'b0;
                end
        end

        holdOnStall: assert property (@(posedge clk) disable iff (reset)
                iqValid && !iqReady |=> iqValid && $stable(iqData));

endmodule

`default_nettype wire

// File: verilog/ofdmTxMapTop.sv
`default_nettype none

module ofdmTxMapTop #(
        parameter int COUNT_WIDTH = 16
) (
        input  logic              clk,
        input  logic              reset,
        input  ofdmTxPkg::axiAddr sAwaddr,
        input  logic              sAwvalid,
        output logic              sAwready,
        input  ofdmTxPkg::axiData sWdata,
        input  logic [3:0]        sWstrb,
        input  logic              sWvalid,
        output logic              sWready,
        output logic [1:0]        sBresp,
        output logic              sBvalid,
        input  logic              sBready,
        input  ofdmTxPkg::axiAddr sAraddr,
        input  logic              sArvalid,
        output logic              sArready,
        output ofdmTxPkg::axiData sRdata,
        output logic [1:0]        sRresp,
        output logic              sRvalid,
        input  logic              sRready,
        input  logic [7:0]        byteData,
        input  logic              byteValid,
        output logic              byteReady,
        output ofdmTxPkg::iqPair  iqData,
        output logic              iqValid,
        input  logic              iqReady
);

        ofdmTxPkg::modType mode;
        logic              enable;
        logic              busy;
        logic              mapperFull;
        logic              sampleStrobe;

        bitGroupIf grpBus ();

        txMapConfig #(
                .COUNT_WIDTH (COUNT_WIDTH)
        ) regs (
                .clk          (clk),
                .reset        (reset),
                .awaddr       (sAwaddr),
                .awvalid      (sAwvalid),
                .awready      (sAwready),
                .wdata        (sWdata),
                .wstrb        (sWstrb),
                .wvalid       (sWvalid),
                .wready       (sWready),
                .bresp        (sBresp),
                .bvalid       (sBvalid),
                .bready       (sBready),
                .araddr       (sAraddr),
                .arvalid      (sArvalid),
                .arready      (sArready),
                .rdata        (sRdata),
                .rresp        (sRresp),
                .rvalid       (sRvalid),
                .rready       (sRready),
                .mode         (mode),
                .enable       (enable),
                .busy         (busy),
                .sampleStrobe (sampleStrobe)
        );

        bitGrouper grouper (
                .clk        (clk),
                .reset      (reset),
                .mode       (mode),
                .enable     (enable),
                .byteData   (byteData),
                .byteValid  (byteValid),
                .byteReady  (byteReady),
                .grp        (grpBus.source),
                .mapperFull (mapperFull),
                .busy       (busy)
        );

        modulation mapper (
                .clk          (clk),
                .reset        (reset),
                .grp          (grpBus.sink),
                .iqData       (iqData),
                .iqValid      (iqValid),
                .iqReady      (iqReady),
                .full         (mapperFull),
                .sampleStrobe (sampleStrobe)
        );

endmodule

`default_nettype wire

// File: verification/ofdmTxMapTb.sv
`default_nettype none

module ofdmTxMapTb;

        localparam int BYTES_LOW       = 16;    // BPSK and QPSK runs
        localparam int BYTES_QAM       = 24;    // 16-QAM, 64-QAM and back-pressure runs
        localparam int BYTES_GATE      = 16;
        localparam int TOTAL_BYTES     = 2 * BYTES_LOW + 3 * BYTES_QAM + BYTES_GATE;
        localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 40;

        logic              clk;
        logic              reset;
        ofdmTxPkg::axiAddr sAwaddr;
        logic              sAwvalid;
        logic              sAwready;
        ofdmTxPkg::axiData sWdata;
        logic [3:0]        sWstrb;
        logic              sWvalid;
        logic              sWready;
        logic [1:0]        sBresp;
        logic              sBvalid;
        logic              sBready;
        ofdmTxPkg::axiAddr sAraddr;
        logic              sArvalid;
        logic              sArready;
        ofdmTxPkg::axiData sRdata;
        logic [1:0]        sRresp;
        logic              sRvalid;
        logic              sRready;
        logic [7:0]        byteData;
        logic              byteValid;
        logic              byteReady;
        ofdmTxPkg::iqPair  iqData;
        logic              iqValid;
        logic              iqReady;

        logic [31:0] dataSeed;
        logic [31:0] readySeed;
        logic        throttle;
        logic        streamBits[$];     // Sent bits in stream order, LSB of each byte first
        logic [31:0] expQ[$];
        logic [31:0] rxQ[$];
        int          errors;
        int          checks;
        int          pairTotal;

        ofdmTxMapTop #(
                .COUNT_WIDTH (16)
        ) dut (.*);

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        ////////////////////////////////////////////////////////////////////////////
        // Reference model

        function automatic logic [31:0] lcgNext(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        function automatic int bitsPerSymbol(input ofdmTxPkg::modType m);
                case (m)
                        ofdmTxPkg::MOD_BPSK:  return 1;
                        ofdmTxPkg::MOD_QPSK:  return 2;
                        ofdmTxPkg::MOD_QAM16: return 4;
                        default:              return 6;
                endcase
        endfunction

        // One amplitude step in Q2.14 is 16384 over the root of the mean energy
        function automatic int levelStep(input ofdmTxPkg::modType m);
                case (m)
                        ofdmTxPkg::MOD_BPSK:  return 16384;
                        ofdmTxPkg::MOD_QPSK:  return 11585;     // 1/sqrt(2)
                        ofdmTxPkg::MOD_QAM16: return 5181;      // 1/sqrt(10)
                        default:              return 2528;      // 1/sqrt(42)
                endcase
        endfunction

        // Bit 0 is the sign and the other bits Gray-code the magnitude with the first bit on top
        function automatic logic [15:0] expectedLevel(input int axisBits, input logic [2:0] b,
                                                      input int step);
                int bin;
                int mag;
                int k;
                bin = 0;
                for (k = 1; k < axisBits; k++) begin
                        bin = (bin << 1) | ((bin & 1) ^ int'(b[k]));
                end
                mag = ((1 << axisBits) - 1 - 2 * bin) * step;
                return b[0] ? 16'(mag) : 16'(-mag);
        endfunction

        function automatic logic [31:0] expectedPair(input ofdmTxPkg::modType m,
                                                     input logic [5:0] g);
                int          half;
                int          step;
                int          k;
                logic [2:0]  iBits;
                logic [2:0]  qBits;
                logic [15:0] qLevel;
                half = (m == ofdmTxPkg::MOD_BPSK) ? 1 : bitsPerSymbol(m) / 2;
                step = levelStep(m);
                for (k = 0; k < 3; k++) begin
                        iBits[k] = (k < half) ? g[k] : 1'b0;
                        qBits[k] = (k < half) ? g[k + half] : 1'b0;
                end
                qLevel = (m == ofdmTxPkg::MOD_BPSK) ? 16'h0000 : expectedLevel(half, qBits, step);
                return {expectedLevel(half, iBits, step), qLevel};
        endfunction

        task automatic modelGroups(input ofdmTxPkg::modType m);
                int         n;
                int         k;
                logic [5:0] g;
                n = bitsPerSymbol(m);
                while (streamBits.size() >= n) begin
                        g = '0;
                        for (k = 0; k < n; k++) begin
                                g[k] = streamBits.pop_front();
                        end
                        expQ.push_back(expectedPair(m, g));
                end
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Bus and stream tasks

        task automatic checkEq(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
                checks++;
                if (expected !== actual) begin
                        errors++;
                        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
                end
        endtask

        task automatic axiWrite(input ofdmTxPkg::axiAddr addr, input ofdmTxPkg::axiData data,
                                input string name);
                logic awDone;
                logic wDone;
                awDone = 1'b0;
                wDone  = 1'b0;
                @(posedge clk);
                sAwaddr  <= addr;
                sAwvalid <= 1'b1;
                sWdata   <= data;
                sWstrb   <= 4'hF;
                sWvalid  <= 1'b1;
                sBready  <= 1'b1;
                while (!(awDone && wDone)) begin
                        @(negedge clk);
                        awDone = awDone || (sAwvalid && sAwready);
                        wDone  = wDone || (sWvalid && sWready);
                        @(posedge clk);
                        if (awDone) begin
                                sAwvalid <= 1'b0;
                        end
                        if (wDone) begin
                                sWvalid <= 1'b0;
                        end
                end
                @(negedge clk);
                while (!sBvalid) begin
                        @(negedge clk);
                end
                checkEq({name, " bresp"}, 32'd0, 32'(sBresp));
                @(posedge clk);
                sBready <= 1'b0;
        endtask

        task automatic axiRead(input ofdmTxPkg::axiAddr addr, output ofdmTxPkg::axiData data,
                               input string name);
                @(posedge clk);
                sAraddr  <= addr;
                sArvalid <= 1'b1;
                sRready  <= 1'b1;
                @(negedge clk);
                while (!sArready) begin
                        @(negedge clk);
                end
                @(posedge clk);
                sArvalid <= 1'b0;
                @(negedge clk);
                while (!sRvalid) begin
                        @(negedge clk);
                end
                data = sRdata;
                checkEq({name, " rresp"}, 32'd0, 32'(sRresp));
                @(posedge clk);
                sRready <= 1'b0;
        endtask

        task automatic sendBytes(input int count);
                logic [7:0] b;
                int         i;
                int         k;
                for (i = 0; i < count; i++) begin
                        dataSeed = lcgNext(dataSeed);
                        b = dataSeed[23:16];
                        @(posedge clk);
                        byteData  <= b;
                        byteValid <= 1'b1;
                        @(negedge clk);
                        while (!byteReady) begin
                                @(negedge clk);
                        end
                        for (k = 0; k < 8; k++) begin
                                streamBits.push_back(b[k]);
                        end
                end
                @(posedge clk);
                byteValid <= 1'b0;
        endtask

        task automatic checkPairs(input string name, input int expectedCount);
                int i;
                while (rxQ.size() < expQ.size()) begin
                        @(negedge clk);
                end
                repeat (10) @(negedge clk);     // Room for a stray extra pair to show up
                checkEq({name, " pair count"}, 32'(expectedCount), 32'(rxQ.size()));
                for (i = 0; i < expQ.size() && i < rxQ.size(); i++) begin
                        checkEq($sformatf("%s pair %0d", name, i), expQ[i], rxQ[i]);
                end
                pairTotal += expectedCount;
                rxQ.delete();
                expQ.delete();
        endtask

        task automatic runMapping(input string name, input ofdmTxPkg::modType m, input int count);
                axiWrite(ofdmTxPkg::REG_CTRL, {29'd0, 1'b1, m}, name);
                sendBytes(count);
                modelGroups(m);
                checkPairs(name, 8 * count / bitsPerSymbol(m));
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Tests

        task automatic testRegisters();
                ofdmTxPkg::axiData v;
                axiRead(ofdmTxPkg::REG_CTRL, v, "registers");
                checkEq("registers ctrl after reset", 32'd0, v);
                axiRead(ofdmTxPkg::REG_COUNT, v, "registers");
                checkEq("registers count after reset", 32'd0, v);
                axiWrite(ofdmTxPkg::REG_CTRL, 32'h0000_0006, "registers");
                axiRead(ofdmTxPkg::REG_CTRL, v, "registers");
                checkEq("registers ctrl readback", 32'h0000_0006, v);
                axiWrite(4'hC, 32'hFFFF_FFFF, "registers");
                axiRead(4'hC, v, "registers");
                checkEq("registers unmapped read", 32'd0, v);
                axiRead(ofdmTxPkg::REG_CTRL, v, "registers");
                checkEq("registers ctrl after unmapped write", 32'h0000_0006, v);
        endtask

        task automatic testLowOrder();
                runMapping("bpsk mapping", ofdmTxPkg::MOD_BPSK, BYTES_LOW);
                runMapping("qpsk mapping", ofdmTxPkg::MOD_QPSK, BYTES_LOW);
        endtask

        task automatic testHighOrder();
                runMapping("qam16 mapping", ofdmTxPkg::MOD_QAM16, BYTES_QAM);
                runMapping("qam64 mapping", ofdmTxPkg::MOD_QAM64, BYTES_QAM);
        endtask

        task automatic testBackPressure();
                @(negedge clk);
                throttle = 1'b1;
                runMapping("back-pressure", ofdmTxPkg::MOD_QAM64, BYTES_QAM);
                @(negedge clk);
                throttle = 1'b0;
        endtask

        task automatic testCounter();
                ofdmTxPkg::axiData v;
                axiRead(ofdmTxPkg::REG_STATUS, v, "counter");
                checkEq("counter status idle", 32'd0, v);
                axiRead(ofdmTxPkg::REG_COUNT, v, "counter");
                checkEq("counter total", 32'(pairTotal), v);
                axiWrite(ofdmTxPkg::REG_COUNT, 32'd0, "counter");
                axiRead(ofdmTxPkg::REG_COUNT, v, "counter");
                checkEq("counter cleared", 32'd0, v);
                pairTotal = 0;
        endtask

        task automatic testEnableGate();
                ofdmTxPkg::axiData v;
                axiWrite(ofdmTxPkg::REG_CTRL, {29'd0, 1'b0, ofdmTxPkg::MOD_QAM16}, "enable gate");
                @(posedge clk);
                byteData  <= 8'hA5;
                byteValid <= 1'b1;
                repeat (50) begin
                        @(negedge clk);
                        checkEq("enable gate byteReady", 32'd0, 32'(byteReady));
                end
                checkEq("enable gate idle pairs", 32'd0, 32'(rxQ.size()));
                @(posedge clk);
                byteValid <= 1'b0;
                runMapping("enable gate resume", ofdmTxPkg::MOD_QAM16, BYTES_GATE);
                axiRead(ofdmTxPkg::REG_COUNT, v, "enable gate");
                checkEq("enable gate count", 32'(pairTotal), v);
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Processes

        always @(negedge clk) begin
                if (!reset && iqValid && iqReady) begin
                        rxQ.push_back(iqData);          // Transfer lands on the next rising edge
                end
        end

        initial begin
                readySeed = 32'd74;
                iqReady <= 1'b1;
                forever begin
                        @(posedge clk);
                        if (throttle) begin
                                readySeed = lcgNext(readySeed);
                                iqReady <= (readySeed[31:24] < 8'd77);  // About 30 percent high
                        end else begin
                                iqReady <= 1'b1;
                        end
                end
        end

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge clk);
                $display("Timeout: the DUT stopped handshaking before the tests finished");
                $display("RESULT: FAIL");
                $finish;
        end

        initial begin
                errors    = 0;
                checks    = 0;
                pairTotal = 0;
                dataSeed  = 32'd74;
                throttle  = 1'b0;
                reset     <= 1'b1;
                sAwaddr   <= '0;
                sAwvalid  <= 1'b0;
                sWdata    <= '0;
                sWstrb    <= '0;
                sWvalid   <= 1'b0;
                sBready   <= 1'b0;
                sAraddr   <= '0;
                sArvalid  <= 1'b0;
                sRready   <= 1'b0;
                byteData  <= '0;
                byteValid <= 1'b0;
                repeat (3) @(posedge clk);
                reset <= 1'b0;
                testRegisters();
                testLowOrder();
                testHighOrder();
                testBackPressure();
                testCounter();
                testEnableGate();
                $display("Checks run: %0d, errors: %0d", checks, errors);
                if (errors == 0) begin
                        $display("RESULT: PASS");
                end else begin
                        $display("RESULT: FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: flist.f
verilog/ofdmTxPkg.sv
verilog/bitGroupIf.sv
verilog/txMapConfig.sv
verilog/bitGrouper.sv
verilog/modulation.sv
verilog/ofdmTxMapTop.sv
verification/ofdmTxMapTb.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
        --top-module ofdmTxMapTb -f flist.f -o ofdmTxMapSim \
        && ./obj_dir/ofdmTxMapSim > sim.log 2>&1 \
        || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log

! grep -q "RESULT: FAIL" sim.log && grep -q "RESULT: PASS" sim.log \
        || { echo "Simulation reported failure"; exit 1; }

exit 0
